// File: ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // Palette and tile geometry
    localparam int PALETTE_ENTRIES = 8;
    localparam int TILE_ROWS       = 16;   // Lines per tile
    localparam int TILES_PER_WORD  = 4;    // Tile map entries per 32-bit word

    // Memory address widths
    localparam int MAP_ADDR_W = 9;
    localparam int GFX_ADDR_W = 11;
    localparam int PAL_ADDR_W = 3;

    typedef logic [23:0] rgb_t;

    // One byte of a tile map word, tile 0 in the lowest byte
    typedef struct packed {
        logic       palette_sel;
        logic [6:0] tile_id;
    } tile_entry_t;

    // One line of a tile, pixel 0 in the lowest two bits
    typedef logic [15:0][1:0] gfx_word_t;

    // Line buffer entry
    typedef struct packed {
        logic      palette_sel;
        gfx_word_t gfx;
    } line_tile_t;

    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        vblank;
        logic        hsync;
    } vga_timing_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ACTIVE,
        FETCH_DONE
    } fetch_state_t;

endpackage

`default_nettype wire

// File: palette_cache.sv
`timescale 1ns/1ps
`default_nettype none

module palette_cache import ppu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  vblank,
    output logic      [PAL_ADDR_W-1:0] palette_addr,
    input  wire rgb_t                  palette_data,
    input  wire logic [2:0]            pal_index,
    output rgb_t                       pixel_color
);

    localparam int PTR_W = $clog2(PALETTE_ENTRIES + 2);

    logic [PTR_W-1:0]      load_ptr;    // Cycle count since vblank rose
    logic [PAL_ADDR_W-1:0] load_slot;   // Entry whose data is on palette_data
    logic                  capture;
    rgb_t                  palette [PALETTE_ENTRIES];

    // Address leads the returned data by one cycle
    assign palette_addr = (load_ptr < PTR_W'(PALETTE_ENTRIES)) ? PAL_ADDR_W'(load_ptr) : '0;
    assign load_slot    = PAL_ADDR_W'(load_ptr - PTR_W'(1));
    assign capture      = vblank && (load_ptr != '0)
                          && (load_ptr <= PTR_W'(PALETTE_ENTRIES));

    always_ff @(posedge clk) begin
        if (reset) begin
            load_ptr <= '0;
        end else if (!vblank) begin
            load_ptr <= '0;                                 // Rearm for next frame
        end else if (load_ptr <= PTR_W'(PALETTE_ENTRIES)) begin
            load_ptr <= load_ptr + PTR_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PALETTE_ENTRIES; i++) begin
                palette[i] <= '0;
            end
        end else if (capture) begin
            palette[load_slot] <= palette_data;
        end
    end

    // Color lookup, one cycle behind pal_index
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else begin
            pixel_color <= palette[pal_index];
        end
    end

endmodule

`default_nettype wire

// File: line_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module line_fetcher import ppu_pkg::*; #(
    parameter int TILES_PER_LINE = 40
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire vga_timing_t            timing,
    output logic       [MAP_ADDR_W-1:0] map_addr,
    input  wire logic  [31:0]           map_data,
    output logic       [GFX_ADDR_W-1:0] gfx_addr,
    input  wire gfx_word_t              gfx_data,
    output logic                        wr_en,
    output logic       [5:0]            wr_index,
    output line_tile_t                  wr_tile
);

    localparam int MAP_STRIDE = TILES_PER_LINE / TILES_PER_WORD;
    localparam int STEP_W     = $clog2(TILES_PER_LINE + 2);

    fetch_state_t                     state;
    logic [STEP_W-1:0]                step;        // Cycle count since hsync rose
    logic                             fetching;
    logic                             map_valid;
    logic                             gfx_valid;
    logic [4:0]                       tile_row;
    logic [3:0]                       fine_row;
    logic [1:0]                       gfx_slot;    // Entry of the word for this gfx read
    tile_entry_t [TILES_PER_WORD-1:0] map_hold;
    tile_entry_t [TILES_PER_WORD-1:0] cur_word;
    tile_entry_t                      cur_entry;
    logic                             sel_q;

    assign tile_row = timing.vcount[9:5];
    assign fine_row = timing.vcount[4:1];              // Vertical doubling

    assign fetching  = timing.hsync && (state != FETCH_DONE);
    assign map_valid = fetching && (step[1:0] == 2'd0) && (step < STEP_W'(TILES_PER_LINE));
    assign gfx_valid = fetching && (step != '0) && (step <= STEP_W'(TILES_PER_LINE));

    // Tile map word w goes out in cycle 4w
    assign map_addr = map_valid ?
        MAP_ADDR_W'(tile_row * MAP_STRIDE + int'(step >> 2)) : '0;

    // Entry 0 of a word is used in the cycle it returns, later ones from the hold register
    assign gfx_slot  = step[1:0] - 2'd1;
    assign cur_word  = (step[1:0] == 2'd1) ? map_data : map_hold;
    assign cur_entry = cur_word[gfx_slot];

    assign gfx_addr = gfx_valid ?
        GFX_ADDR_W'(cur_entry.tile_id * TILE_ROWS + fine_row) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH_IDLE;
            step  <= '0;
        end else if (!timing.hsync) begin
            state <= FETCH_IDLE;
            step  <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    state <= FETCH_ACTIVE;
                    step  <= step + STEP_W'(1);
                end
                FETCH_ACTIVE: begin
                    if (step == STEP_W'(TILES_PER_LINE + 1)) begin
                        state <= FETCH_DONE;                    // Last write this cycle
                    end else begin
                        step <= step + STEP_W'(1);
                    end
                end
                default: begin
                    state <= FETCH_DONE;
                end
            endcase
        end
    end

    // Hold the tile map word for entries 1 to 3
    always_ff @(posedge clk) begin
        if (fetching && (step[1:0] == 2'd1)) begin
            map_hold <= map_data;
        end
    end

    // Tile index and palette select follow the graphics read by one cycle
    always_ff @(posedge clk) begin
        wr_index <= 6'(step - STEP_W'(1));
        sel_q    <= cur_entry.palette_sel;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= gfx_valid;
        end
    end

    assign wr_tile.palette_sel = sel_q;
    assign wr_tile.gfx         = gfx_data;   // Graphics word lands this cycle

endmodule

`default_nettype wire

// File: line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer import ppu_pkg::*; #(
    parameter int TILES_PER_LINE = 40
) (
    input  wire logic       clk,
    input  wire logic       wr_en,
    input  wire logic [5:0] wr_index,
    input  wire line_tile_t wr_tile,
    input  wire logic [5:0] rd_index,
    output line_tile_t      rd_tile
);

    line_tile_t entries [TILES_PER_LINE];

    // Filled during hsync by the fetcher
    always_ff @(posedge clk) begin
        if (wr_en && (wr_index < 6'(TILES_PER_LINE))) begin
            entries[wr_index] <= wr_tile;
        end
    end

    // Read is combinational so a load sees the tile in the cycle it is selected
    assign rd_tile = entries[rd_index];

endmodule

`default_nettype wire

// File: background_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module background_shifter import ppu_pkg::*; #(
    parameter int TILES_PER_LINE = 40
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire vga_timing_t timing,
    output logic [5:0]       rd_index,
    input  wire line_tile_t  rd_tile,
    output logic [2:0]       pal_index
);

    logic [5:0] cur_tile;
    logic [5:0] next_tile;
    logic       load;
    logic       shift;
    gfx_word_t  pixels;      // Pixel 0 of what remains sits in the low bits
    logic       sel_q;

    assign cur_tile  = timing.hcount[10:5];
    assign next_tile = (cur_tile >= 6'(TILES_PER_LINE - 1)) ? 6'd0 : cur_tile + 6'd1;

    // Tile 0 is preloaded throughout hsync
    assign rd_index = timing.hsync ? 6'd0 : next_tile;
    assign load     = timing.hsync || (timing.hcount[4:0] == 5'd31);
    assign shift    = timing.hcount[0];                // Every other cycle, doubles pixels

    always_ff @(posedge clk) begin
        if (reset) begin
            pixels <= '0;
            sel_q  <= 1'b0;
        end else if (load) begin
            pixels <= rd_tile.gfx;
            sel_q  <= rd_tile.palette_sel;
        end else if (shift) begin
            pixels <= pixels >> 2;
        end
    end

    // Palette select picks the upper or lower four colors
    assign pal_index = {sel_q, pixels[0]};

endmodule

`default_nettype wire

// File: ppu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_top import ppu_pkg::*; #(
    parameter int TILES_PER_LINE = 40
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire vga_timing_t           timing,
    output logic      [PAL_ADDR_W-1:0] palette_addr,
    input  wire rgb_t                  palette_data,
    output logic      [MAP_ADDR_W-1:0] map_addr,
    input  wire logic [31:0]           map_data,
    output logic      [GFX_ADDR_W-1:0] gfx_addr,
    input  wire gfx_word_t             gfx_data,
    output rgb_t                       pixel_color
);

    logic       wr_en;
    logic [5:0] wr_index;
    line_tile_t wr_tile;
    logic [5:0] rd_index;
    line_tile_t rd_tile;
    logic [2:0] pal_index;

    palette_cache palette_cache_i (
        .clk          (clk),
        .reset        (reset),
        .vblank       (timing.vblank),
        .palette_addr (palette_addr),
        .palette_data (palette_data),
        .pal_index    (pal_index),
        .pixel_color  (pixel_color)
    );

    line_fetcher #(.TILES_PER_LINE(TILES_PER_LINE)) line_fetcher_i (
        .clk      (clk),
        .reset    (reset),
        .timing   (timing),
        .map_addr (map_addr),
        .map_data (map_data),
        .gfx_addr (gfx_addr),
        .gfx_data (gfx_data),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tile  (wr_tile)
    );

    line_buffer #(.TILES_PER_LINE(TILES_PER_LINE)) line_buffer_i (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tile  (wr_tile),
        .rd_index (rd_index),
        .rd_tile  (rd_tile)
    );

    background_shifter #(.TILES_PER_LINE(TILES_PER_LINE)) background_shifter_i (
        .clk       (clk),
        .reset     (reset),
        .timing    (timing),
        .rd_index  (rd_index),
        .rd_tile   (rd_tile),
        .pal_index (pal_index)
    );

endmodule

`default_nettype wire

// File: tb_ppu_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_mem import ppu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  refill_palette,
    input  wire logic [PAL_ADDR_W-1:0] palette_addr,
    output rgb_t                       palette_data,
    input  wire logic [MAP_ADDR_W-1:0] map_addr,
    output logic      [31:0]           map_data,
    input  wire logic [GFX_ADDR_W-1:0] gfx_addr,
    output gfx_word_t                  gfx_data
);

    localparam int MAP_WORDS = 1 << MAP_ADDR_W;
    localparam int GFX_WORDS = 1 << GFX_ADDR_W;

    rgb_t        pal_mem [PALETTE_ENTRIES];
    logic [31:0] map_mem [MAP_WORDS];
    gfx_word_t   gfx_mem [GFX_WORDS];

    task automatic fill_palette();
        for (int i = 0; i < PALETTE_ENTRIES; i++) begin
            pal_mem[PAL_ADDR_W'(i)] = rgb_t'($urandom());
        end
    endtask

    // One random stream fills everything, palette refills included
    initial begin
        void'($urandom(32'h6bf6));
        fill_palette();
        for (int i = 0; i < MAP_WORDS; i++) begin
            map_mem[MAP_ADDR_W'(i)] = $urandom();
        end
        for (int i = 0; i < GFX_WORDS; i++) begin
            gfx_mem[GFX_ADDR_W'(i)] = $urandom();
        end
        forever begin
            @(posedge refill_palette);
            fill_palette();                         // New colors for the next frame
        end
    end

    // Data for an address appears one cycle later
    always_ff @(posedge clk) begin
        palette_data <= pal_mem[palette_addr];
        map_data     <= map_mem[map_addr];
        gfx_data     <= gfx_mem[gfx_addr];
    end

endmodule

`default_nettype wire

// File: tb_ppu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ppu import ppu_pkg::*; ();

    localparam int TILES_PER_LINE  = 40;
    localparam int STRIDE          = TILES_PER_LINE / TILES_PER_WORD;
    localparam int LINE_PIXELS     = 32 * TILES_PER_LINE;
    localparam int VBLANK_CYCLES   = 12;
    localparam int HSYNC_CYCLES    = 64;
    localparam int LINES_PER_FRAME = 3;
    localparam int FRAMES          = 2;
    localparam int MAX_CYCLES      = 20000;

    // Lines spread over tile_row and fine_row
    localparam logic [9:0] LINE_LIST [FRAMES * LINES_PER_FRAME] = '{
        10'd0, 10'd37, 10'd302, 10'd126, 10'd799, 10'd1023
    };

    logic                  clk;
    logic                  reset;
    vga_timing_t           timing;
    logic                  refill_palette;
    logic [PAL_ADDR_W-1:0] palette_addr;
    rgb_t                  palette_data;
    logic [MAP_ADDR_W-1:0] map_addr;
    logic [31:0]           map_data;
    logic [GFX_ADDR_W-1:0] gfx_addr;
    gfx_word_t             gfx_data;
    rgb_t                  pixel_color;

    // Expected values for the coming rising edge
    logic                  chk_reset;
    logic                  chk_pal;
    logic [PAL_ADDR_W-1:0] exp_pal;
    logic                  chk_map;
    logic [MAP_ADDR_W-1:0] exp_map;
    logic                  chk_gfx;
    logic [GFX_ADDR_W-1:0] exp_gfx;
    logic                  chk_pixel;
    rgb_t                  exp_pixel;
    rgb_t                  pal_model [PALETTE_ENTRIES];
    logic                  prev_active;
    logic [10:0]           prev_h;
    int                    errors_reset;
    int                    errors_pal;
    int                    errors_map;
    int                    errors_gfx;
    int                    errors_pixel;
    int                    errors_other;

    ppu_top #(.TILES_PER_LINE(TILES_PER_LINE)) dut_i (
        .clk          (clk),
        .reset        (reset),
        .timing       (timing),
        .palette_addr (palette_addr),
        .palette_data (palette_data),
        .map_addr     (map_addr),
        .map_data     (map_data),
        .gfx_addr     (gfx_addr),
        .gfx_data     (gfx_data),
        .pixel_color  (pixel_color)
    );

    tb_ppu_mem mem_i (
        .clk            (clk),
        .refill_palette (refill_palette),
        .palette_addr   (palette_addr),
        .palette_data   (palette_data),
        .map_addr       (map_addr),
        .map_data       (map_data),
        .gfx_addr       (gfx_addr),
        .gfx_data       (gfx_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        for (int n = 0; n < MAX_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    reset_outputs_zero: assert property (@(posedge clk) chk_reset |->
        (pixel_color == '0 && map_addr == '0 && gfx_addr == '0 && palette_addr == '0))
        else begin
            errors_reset++;
            $display("error at %0t ns: outputs not 0 at reset (color %h map %0d gfx %0d pal %0d)",
                     $time, $sampled(pixel_color), $sampled(map_addr), $sampled(gfx_addr),
                     $sampled(palette_addr));
        end

    palette_addr_seq: assert property (@(posedge clk) chk_pal |-> palette_addr == exp_pal)
        else begin
            errors_pal++;
            $display("error at %0t ns: palette_addr %0d, expected %0d",
                     $time, $sampled(palette_addr), $sampled(exp_pal));
        end

    map_addr_seq: assert property (@(posedge clk) chk_map |-> map_addr == exp_map)
        else begin
            errors_map++;
            $display("error at %0t ns: map_addr %0d, expected %0d",
                     $time, $sampled(map_addr), $sampled(exp_map));
        end

    gfx_addr_seq: assert property (@(posedge clk) chk_gfx |-> gfx_addr == exp_gfx)
        else begin
            errors_gfx++;
            $display("error at %0t ns: gfx_addr %0d, expected %0d",
                     $time, $sampled(gfx_addr), $sampled(exp_gfx));
        end

    pixel_match: assert property (@(posedge clk) chk_pixel |-> pixel_color == exp_pixel)
        else begin
            errors_pixel++;
            $display("error at %0t ns: pixel_color %h, expected %h",
                     $time, $sampled(pixel_color), $sampled(exp_pixel));
        end

    function automatic tile_entry_t map_entry(input logic [9:0] vc, input int tile);
        logic [31:0] word;
        word = mem_i.map_mem[MAP_ADDR_W'(int'(vc[9:5]) * STRIDE + tile / TILES_PER_WORD)];
        return tile_entry_t'(8'(word >> (8 * (tile % TILES_PER_WORD))));  // Tile 0 in low byte
    endfunction

    function automatic rgb_t expected_color(input logic [9:0] vc, input logic [10:0] h);
        tile_entry_t entry;
        gfx_word_t   gfx;
        entry = map_entry(vc, int'(h[10:5]));
        gfx   = mem_i.gfx_mem[GFX_ADDR_W'(int'(entry.tile_id) * TILE_ROWS + int'(vc[4:1]))];
        return pal_model[{entry.palette_sel, gfx[h[4:1]]}];    // Pixel (h>>1) mod 16
    endfunction

    task automatic advance(input logic active, input logic [10:0] h);
        @(negedge clk);
        chk_pixel = prev_active;                 // Color of the previous hcount is due now
        if (prev_active) begin
            exp_pixel = expected_color(timing.vcount, prev_h);
        end
        prev_active = active;
        prev_h      = h;
        chk_pal     = 1'b1;                      // Load pointer idles outside vblank
        exp_pal     = '0;
        chk_map     = 1'b0;
        chk_gfx     = 1'b0;
    endtask

    task automatic idle_cycle();
        advance(1'b0, 11'd0);
        timing = '0;
    endtask

    task automatic vblank_cycle(input int i);
        advance(1'b0, 11'd0);
        timing  = '{hcount: 11'd0, vcount: 10'd0, vblank: 1'b1, hsync: 1'b0};
        chk_pal = (i != PALETTE_ENTRIES);
        exp_pal = (i < PALETTE_ENTRIES) ? PAL_ADDR_W'(i) : '0;
    endtask

    task automatic hsync_cycle(input logic [9:0] vc, input int s);
        tile_entry_t entry;
        advance(1'b0, 11'd0);
        timing = '{hcount: 11'd0, vcount: vc, vblank: 1'b0, hsync: 1'b1};
        if ((s % TILES_PER_WORD == 0) && (s < TILES_PER_LINE)) begin
            chk_map = 1'b1;
            exp_map = MAP_ADDR_W'(int'(vc[9:5]) * STRIDE + s / TILES_PER_WORD);
        end else if (s >= TILES_PER_LINE) begin
            chk_map = 1'b1;
            exp_map = '0;
        end
        if ((s >= 1) && (s <= TILES_PER_LINE)) begin
            entry   = map_entry(vc, s - 1);          // Tile t is read in cycle t+1
            chk_gfx = 1'b1;
            exp_gfx = GFX_ADDR_W'(int'(entry.tile_id) * TILE_ROWS + int'(vc[4:1]));
        end else if (s > TILES_PER_LINE) begin
            chk_gfx = 1'b1;
            exp_gfx = '0;
        end
    endtask

    task automatic active_cycle(input logic [9:0] vc, input int h);
        advance(1'b1, 11'(h));
        timing = '{hcount: 11'(h), vcount: vc, vblank: 1'b0, hsync: 1'b0};
    endtask

    task automatic load_palette_model(input logic check_change);
        int changed;
        changed = 0;
        for (int i = 0; i < PALETTE_ENTRIES; i++) begin
            if (mem_i.pal_mem[PAL_ADDR_W'(i)] != pal_model[PAL_ADDR_W'(i)]) begin
                changed++;
            end
            pal_model[PAL_ADDR_W'(i)] = mem_i.pal_mem[PAL_ADDR_W'(i)];
        end
        palette_refilled: assert (!check_change || (changed != 0))
            else begin
                errors_other++;
                $display("The palette refill left every palette memory entry unchanged");
            end
    endtask

    task automatic run_frame(input int frame);
        logic [9:0] vc;
        idle_cycle();                            // Flushes the last pixel of the previous frame
        if (frame > 0) begin
            refill_palette = 1'b1;
            idle_cycle();
            refill_palette = 1'b0;
        end
        load_palette_model(frame > 0);
        for (int i = 0; i < VBLANK_CYCLES; i++) begin
            vblank_cycle(i);
        end
        for (int l = 0; l < LINES_PER_FRAME; l++) begin
            vc = LINE_LIST[3'(frame * LINES_PER_FRAME + l)];
            for (int s = 0; s < HSYNC_CYCLES; s++) begin
                hsync_cycle(vc, s);
            end
            for (int h = 0; h < LINE_PIXELS; h++) begin
                active_cycle(vc, h);
            end
        end
    endtask

    initial begin
        int total;
        reset          = 1'b1;
        timing         = '0;
        refill_palette = 1'b0;
        chk_reset      = 1'b0;
        chk_pal        = 1'b0;
        exp_pal        = '0;
        chk_map        = 1'b0;
        exp_map        = '0;
        chk_gfx        = 1'b0;
        exp_gfx        = '0;
        chk_pixel      = 1'b0;
        exp_pixel      = '0;
        prev_active    = 1'b0;
        prev_h         = '0;
        errors_reset   = 0;
        errors_pal     = 0;
        errors_map     = 0;
        errors_gfx     = 0;
        errors_pixel   = 0;
        errors_other   = 0;
        for (int i = 0; i < PALETTE_ENTRIES; i++) begin
            pal_model[PAL_ADDR_W'(i)] = '0;
        end

        idle_cycle();
        chk_reset = 1'b1;                        // Flops are settled after the first edge
        timing    = '{hcount: 11'd0, vcount: 10'd0, vblank: 1'b1, hsync: 1'b1};
        advance(1'b0, 11'd0);                    // Both fetch windows open so only reset holds 0
        advance(1'b0, 11'd0);
        idle_cycle();
        reset = 1'b0;
        idle_cycle();
        idle_cycle();
        chk_reset = 1'b0;

        for (int f = 0; f < FRAMES; f++) begin
            run_frame(f);
        end
        idle_cycle();
        idle_cycle();

        total = errors_reset + errors_pal + errors_map + errors_gfx + errors_pixel
                + errors_other;
        $display("Errors: reset %0d, pal %0d, map %0d, gfx %0d, pixel %0d, other %0d, total %0d",
                 errors_reset, errors_pal, errors_map, errors_gfx, errors_pixel,
                 errors_other, total);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
ppu_pkg.sv
palette_cache.sv
line_fetcher.sv
line_buffer.sv
background_shifter.sv
ppu_top.sv
tb_ppu_mem.sv
tb_ppu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ppu
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat compile.f)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into $(LOG), check for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR, TOP, LOG, BUILD_DIR, VFLAGS"

$(SIM_BIN): compile.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f compile.f

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "Simulation completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
